//--- hw/riscv_pkg.sv
package riscv_pkg;

    // Data words and addresses share one width
    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [2:0] alu_op_t;

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    // Immediate passed straight through for LUI
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

//--- hw/fetch_stage.sv
module fetch_stage #(
    parameter riscv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              branch_taken,
    input  riscv_pkg::word_t  branch_target,
    input  riscv_pkg::instr_t instr,
    output riscv_pkg::word_t  pc,
    output riscv_pkg::word_t  if_pc,
    output riscv_pkg::instr_t if_instr
);

    // Redirect has priority over stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID instruction squashed to a NOP on redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            if_instr <= riscv_pkg::NOP_INSTR;
        end else if (branch_taken) begin
            if_instr <= riscv_pkg::NOP_INSTR;
        end else if (!stall) begin
            if_instr <= instr;
        end
    end

    // Address of the word held in IF/ID
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc <= pc;
        end
    end

endmodule

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::word_t     if_pc,
    input  riscv_pkg::instr_t    if_instr,
    input  logic                 branch_taken,
    input  riscv_pkg::reg_addr_t wb_rd,
    input  logic                 wb_we,
    input  riscv_pkg::word_t     wb_data,
    output logic                 stall,
    output riscv_pkg::word_t     ex_pc,
    output riscv_pkg::word_t     ex_rs1_val,
    output riscv_pkg::word_t     ex_rs2_val,
    output riscv_pkg::word_t     ex_imm,
    output riscv_pkg::reg_addr_t ex_rs1,
    output riscv_pkg::reg_addr_t ex_rs2,
    output riscv_pkg::reg_addr_t ex_rd,
    output riscv_pkg::alu_op_t   ex_alu_op,
    output logic                 ex_use_imm,
    output logic                 ex_rd_we,
    output logic                 ex_is_load,
    output logic                 ex_is_store,
    output logic                 ex_is_branch,
    output logic                 ex_branch_ne,
    output logic                 ex_is_jal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_s;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm_u;
    riscv_pkg::word_t imm_j;
    riscv_pkg::word_t imm;
    riscv_pkg::alu_op_t arith_op;
    logic arith_ok;
    riscv_pkg::alu_op_t alu_op;
    logic use_imm;
    logic rd_we;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic uses_rs1;
    logic uses_rs2;
    riscv_pkg::word_t regs [32];
    riscv_pkg::word_t rs1_val;
    riscv_pkg::word_t rs2_val;
    logic bubble;

    assign opcode = if_instr[6:0];
    assign rd = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1 = if_instr[19:15];
    assign rs2 = if_instr[24:20];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_u = {if_instr[31:12], 12'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                    if_instr[30:21], 1'b0};

    // funct3 decode shared by register and immediate forms
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            3'b000: arith_op = riscv_pkg::ALU_ADD;
            3'b100: arith_op = riscv_pkg::ALU_XOR;
            3'b110: arith_op = riscv_pkg::ALU_OR;
            3'b111: arith_op = riscv_pkg::ALU_AND;
            default: begin
                arith_op = riscv_pkg::ALU_ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_op = riscv_pkg::ALU_ADD;
        imm = imm_i;
        use_imm = 1'b0;
        rd_we = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            riscv_pkg::OPC_OP_IMM: begin
                alu_op = arith_op;
                use_imm = 1'b1;
                rd_we = arith_ok;
                uses_rs1 = 1'b1;
            end
            riscv_pkg::OPC_OP: begin
                alu_op = (funct3 == 3'b000 && if_instr[30]) ? riscv_pkg::ALU_SUB : arith_op;
                rd_we = arith_ok;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            riscv_pkg::OPC_LUI: begin
                alu_op = riscv_pkg::ALU_PASS_B;
                imm = imm_u;
                use_imm = 1'b1;
                rd_we = 1'b1;
            end
            riscv_pkg::OPC_LOAD: begin
                use_imm = 1'b1;
                rd_we = 1'b1;
                is_load = 1'b1;
                uses_rs1 = 1'b1;
            end
            riscv_pkg::OPC_STORE: begin
                imm = imm_s;
                use_imm = 1'b1;
                is_store = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            riscv_pkg::OPC_BRANCH: begin
                // Only BEQ and BNE
                imm = imm_b;
                is_branch = (funct3[2:1] == 2'b00);
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            riscv_pkg::OPC_JAL: begin
                imm = imm_j;
                rd_we = 1'b1;
                is_jal = 1'b1;
            end
            default: begin
                rd_we = 1'b0;
            end
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads see a write-back from the same cycle
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    // Load in EX feeding a source used here
    assign stall = ex_is_load && ex_rd != '0 &&
                   ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

    assign bubble = stall || branch_taken;

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            ex_alu_op <= riscv_pkg::ALU_ADD;
            ex_use_imm <= 1'b0;
            ex_rd_we <= 1'b0;
            ex_is_load <= 1'b0;
            ex_is_store <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_branch_ne <= 1'b0;
            ex_is_jal <= 1'b0;
        end else begin
            ex_alu_op <= alu_op;
            ex_use_imm <= use_imm;
            ex_rd_we <= rd_we;
            ex_is_load <= is_load;
            ex_is_store <= is_store;
            ex_is_branch <= is_branch;
            ex_branch_ne <= is_branch & funct3[0];
            ex_is_jal <= is_jal;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc <= if_pc;
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
        ex_imm <= imm;
        ex_rs1 <= rs1;
        ex_rs2 <= rs2;
        ex_rd <= rd;
    end

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::word_t     ex_pc,
    input  riscv_pkg::word_t     ex_rs1_val,
    input  riscv_pkg::word_t     ex_rs2_val,
    input  riscv_pkg::word_t     ex_imm,
    input  riscv_pkg::reg_addr_t ex_rs1,
    input  riscv_pkg::reg_addr_t ex_rs2,
    input  riscv_pkg::reg_addr_t ex_rd,
    input  riscv_pkg::alu_op_t   ex_alu_op,
    input  logic                 ex_use_imm,
    input  logic                 ex_rd_we,
    input  logic                 ex_is_load,
    input  logic                 ex_is_store,
    input  logic                 ex_is_branch,
    input  logic                 ex_branch_ne,
    input  logic                 ex_is_jal,
    input  riscv_pkg::reg_addr_t wb_rd,
    input  logic                 wb_we,
    input  riscv_pkg::word_t     wb_data,
    output logic                 branch_taken,
    output riscv_pkg::word_t     branch_target,
    output riscv_pkg::word_t     mem_result,
    output riscv_pkg::word_t     mem_store_data,
    output riscv_pkg::reg_addr_t mem_rd,
    output logic                 mem_rd_we,
    output logic                 mem_is_load,
    output logic                 mem_is_store
);

    riscv_pkg::word_t op_a;
    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_b;
    riscv_pkg::word_t alu_out;
    riscv_pkg::word_t result;
    logic operands_eq;

    // Youngest producer forwards first
    always_comb begin
        if (mem_rd_we && mem_rd != '0 && mem_rd == ex_rs1) begin
            op_a = mem_result;
        end else if (wb_we && wb_rd != '0 && wb_rd == ex_rs1) begin
            op_a = wb_data;
        end else begin
            op_a = ex_rs1_val;
        end
    end

    always_comb begin
        if (mem_rd_we && mem_rd != '0 && mem_rd == ex_rs2) begin
            op_b = mem_result;
        end else if (wb_we && wb_rd != '0 && wb_rd == ex_rs2) begin
            op_b = wb_data;
        end else begin
            op_b = ex_rs2_val;
        end
    end

    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            riscv_pkg::ALU_SUB: alu_out = op_a - alu_b;
            riscv_pkg::ALU_AND: alu_out = op_a & alu_b;
            riscv_pkg::ALU_OR: alu_out = op_a | alu_b;
            riscv_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
            riscv_pkg::ALU_PASS_B: alu_out = alu_b;
            default: alu_out = op_a + alu_b;
        endcase
    end

    // JAL links the return address
    assign result = ex_is_jal ? ex_pc + 32'd4 : alu_out;

    assign operands_eq = (op_a == op_b);
    assign branch_taken = ex_is_jal || (ex_is_branch && (operands_eq ^ ex_branch_ne));
    assign branch_target = ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rd_we <= 1'b0;
            mem_is_load <= 1'b0;
            mem_is_store <= 1'b0;
        end else begin
            mem_rd_we <= ex_rd_we;
            mem_is_load <= ex_is_load;
            mem_is_store <= ex_is_store;
        end
    end

    always_ff @(posedge clk) begin
        mem_result <= result;
        mem_store_data <= op_b;
        mem_rd <= ex_rd;
    end

endmodule

//--- hw/mem_wb_stage.sv
module mem_wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::word_t     mem_result,
    input  riscv_pkg::word_t     mem_store_data,
    input  riscv_pkg::reg_addr_t mem_rd,
    input  logic                 mem_rd_we,
    input  logic                 mem_is_load,
    input  logic                 mem_is_store,
    input  riscv_pkg::word_t     read_data,
    output riscv_pkg::word_t     data_addr,
    output riscv_pkg::word_t     wr_data,
    output logic                 mem_wr_en,
    output logic                 mem_rd_en,
    output riscv_pkg::reg_addr_t wb_rd,
    output logic                 wb_we,
    output riscv_pkg::word_t     wb_data
);

    riscv_pkg::word_t wb_result;
    riscv_pkg::word_t wb_load_data;
    logic wb_is_load;

    // ALU result doubles as the load and store address
    assign data_addr = mem_result;
    assign wr_data = mem_store_data;
    assign mem_wr_en = mem_is_store;
    assign mem_rd_en = mem_is_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_we <= mem_rd_we;
            wb_is_load <= mem_is_load;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= mem_rd;
        wb_result <= mem_result;
        wb_load_data <= read_data;
    end

    assign wb_data = wb_is_load ? wb_load_data : wb_result;

endmodule

//--- hw/riscv_cpu.sv
module riscv_cpu #(
    parameter riscv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  riscv_pkg::instr_t instr,
    input  riscv_pkg::word_t  read_data,
    output riscv_pkg::word_t  pc,
    output riscv_pkg::word_t  data_addr,
    output riscv_pkg::word_t  wr_data,
    output logic              mem_wr_en,
    output logic              mem_rd_en
);

    // IF/ID
    riscv_pkg::word_t if_pc;
    riscv_pkg::instr_t if_instr;
    logic stall;

    // ID/EX
    riscv_pkg::word_t ex_pc;
    riscv_pkg::word_t ex_rs1_val;
    riscv_pkg::word_t ex_rs2_val;
    riscv_pkg::word_t ex_imm;
    riscv_pkg::reg_addr_t ex_rs1;
    riscv_pkg::reg_addr_t ex_rs2;
    riscv_pkg::reg_addr_t ex_rd;
    riscv_pkg::alu_op_t ex_alu_op;
    logic ex_use_imm;
    logic ex_rd_we;
    logic ex_is_load;
    logic ex_is_store;
    logic ex_is_branch;
    logic ex_branch_ne;
    logic ex_is_jal;

    // Redirect from EX
    logic branch_taken;
    riscv_pkg::word_t branch_target;

    // EX/MEM
    riscv_pkg::word_t mem_result;
    riscv_pkg::word_t mem_store_data;
    riscv_pkg::reg_addr_t mem_rd;
    logic mem_rd_we;
    logic mem_is_load;
    logic mem_is_store;

    // Write-back bus
    riscv_pkg::reg_addr_t wb_rd;
    logic wb_we;
    riscv_pkg::word_t wb_data;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch0 (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .instr(instr),
        .pc(pc),
        .if_pc(if_pc),
        .if_instr(if_instr)
    );

    decode_stage decode0 (
        .clk(clk),
        .reset(reset),
        .if_pc(if_pc),
        .if_instr(if_instr),
        .branch_taken(branch_taken),
        .wb_rd(wb_rd),
        .wb_we(wb_we),
        .wb_data(wb_data),
        .stall(stall),
        .ex_pc(ex_pc),
        .ex_rs1_val(ex_rs1_val),
        .ex_rs2_val(ex_rs2_val),
        .ex_imm(ex_imm),
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op),
        .ex_use_imm(ex_use_imm),
        .ex_rd_we(ex_rd_we),
        .ex_is_load(ex_is_load),
        .ex_is_store(ex_is_store),
        .ex_is_branch(ex_is_branch),
        .ex_branch_ne(ex_branch_ne),
        .ex_is_jal(ex_is_jal)
    );

    execute_stage execute0 (
        .clk(clk),
        .reset(reset),
        .ex_pc(ex_pc),
        .ex_rs1_val(ex_rs1_val),
        .ex_rs2_val(ex_rs2_val),
        .ex_imm(ex_imm),
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op),
        .ex_use_imm(ex_use_imm),
        .ex_rd_we(ex_rd_we),
        .ex_is_load(ex_is_load),
        .ex_is_store(ex_is_store),
        .ex_is_branch(ex_is_branch),
        .ex_branch_ne(ex_branch_ne),
        .ex_is_jal(ex_is_jal),
        .wb_rd(wb_rd),
        .wb_we(wb_we),
        .wb_data(wb_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .mem_result(mem_result),
        .mem_store_data(mem_store_data),
        .mem_rd(mem_rd),
        .mem_rd_we(mem_rd_we),
        .mem_is_load(mem_is_load),
        .mem_is_store(mem_is_store)
    );

    mem_wb_stage mem_wb0 (
        .clk(clk),
        .reset(reset),
        .mem_result(mem_result),
        .mem_store_data(mem_store_data),
        .mem_rd(mem_rd),
        .mem_rd_we(mem_rd_we),
        .mem_is_load(mem_is_load),
        .mem_is_store(mem_is_store),
        .read_data(read_data),
        .data_addr(data_addr),
        .wr_data(wr_data),
        .mem_wr_en(mem_wr_en),
        .mem_rd_en(mem_rd_en),
        .wb_rd(wb_rd),
        .wb_we(wb_we),
        .wb_data(wb_data)
    );

endmodule

//--- sim/riscv_cpu_program.svh
// Word i of the program sits at byte address 4*i from RESET_PC = 0
localparam int PROG_LEN = 33;
localparam riscv_pkg::instr_t PROGRAM [PROG_LEN] = '{
    // addi x1,x0,5 / addi x2,x1,7 / lui x3,0x12345 / add x4,x3,x2
    32'h0050_0093,
    32'h0070_8113,
    32'h1234_51b7,
    32'h0021_8233,
    // sub x5,x4,x1 / and x6,x5,x4 / or x7,x6,x1 / xor x8,x7,x2
    32'h4012_02b3,
    32'h0042_f333,
    32'h0013_63b3,
    32'h0023_c433,
    // addi x0,x1,99 then add x9,x0,x1 must still see x0 as zero
    32'h0630_8013,
    32'h0010_04b3,
    // sw x9,0x40 right behind its producer, then x4..x8 to 0x44..0x54
    32'h0490_2023,
    32'h0440_2223,
    32'h0450_2423,
    32'h0460_2623,
    32'h0470_2823,
    32'h0480_2a23,
    // lw x10,0x44 / add x11,x10,x1 / sw x11,0x58
    32'h0440_2503,
    32'h0015_05b3,
    32'h04b0_2c23,
    // addi x12,x0,0xaa / bne x1,x2,+12 over two poison stores
    32'h0aa0_0613,
    32'h0020_9663,
    32'h0ec0_2e23,
    32'h0ec0_2e23,
    // jal x13,+12 over two poison stores, then sw x13,0x5c
    32'h00c0_06ef,
    32'h0ec0_2e23,
    32'h0ec0_2e23,
    32'h04d0_2e23,
    // beq x1,x2,+8 is not taken so sw x1,0x60 goes through
    32'h0020_8463,
    32'h0610_2023,
    // Drain the last store before the halt loop
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    // jal x0,0
    32'h0000_006f
};

localparam riscv_pkg::word_t HALT_PC = 32'h0000_0080;
localparam riscv_pkg::word_t POISON_ADDR = 32'h0000_00fc;
localparam riscv_pkg::word_t LOAD_ADDR = 32'h0000_0044;

// Addresses that pc may jump to
localparam int TARGET_COUNT = 3;
localparam riscv_pkg::word_t BRANCH_TARGETS [TARGET_COUNT] = '{
    32'h0000_005c,
    32'h0000_0068,
    32'h0000_0080
};

// Stores in program order
localparam int STORE_COUNT = 9;
localparam riscv_pkg::word_t EXP_ADDR [STORE_COUNT] = '{
    32'h0000_0040,
    32'h0000_0044,
    32'h0000_0048,
    32'h0000_004c,
    32'h0000_0050,
    32'h0000_0054,
    32'h0000_0058,
    32'h0000_005c,
    32'h0000_0060
};
localparam riscv_pkg::word_t EXP_DATA [STORE_COUNT] = '{
    32'h0000_0005,
    32'h1234_500c,
    32'h1234_5007,
    32'h1234_5004,
    32'h1234_5005,
    32'h1234_5009,
    32'h1234_5011,
    32'h0000_0060,
    32'h0000_0005
};

//--- sim/riscv_cpu_properties.sv
module riscv_cpu_properties #(
    parameter riscv_pkg::word_t RESET_PC = '0
) (
    input logic             clk,
    input logic             reset,
    input riscv_pkg::word_t pc,
    input riscv_pkg::word_t data_addr,
    input riscv_pkg::word_t wr_data,
    input logic             mem_wr_en,
    input logic             mem_rd_en
);
    timeunit 1ns;
    timeprecision 1ps;

    `include "riscv_cpu_program.svh"

    int store_idx;
    int error_count = 0;
    logic halt_seen;

    function automatic logic is_branch_target(riscv_pkg::word_t addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < TARGET_COUNT; i++) begin
            if (BRANCH_TARGETS[i] == addr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Store counter and first arrival at the halt loop
    always @(posedge clk) begin
        if (reset) begin
            store_idx <= 0;
            halt_seen <= 1'b0;
        end else begin
            if (mem_wr_en) begin
                store_idx <= store_idx + 1;
            end
            if (pc == HALT_PC) begin
                halt_seen <= 1'b1;
            end
        end
    end

    reset_pc_check: assert property (@(posedge clk) reset |=> pc == RESET_PC)
        else begin
            $error("Fail at time %0t: pc expected %h, got %h", $time, RESET_PC, $sampled(pc));
            error_count++;
        end

    reset_idle_check: assert property (@(posedge clk) reset |=> !mem_wr_en && !mem_rd_en)
        else begin
            $error("Data memory accessed during or right after reset at time %0t", $time);
            error_count++;
        end

    pc_flow_check: assert property (@(posedge clk) disable iff (reset)
        pc == $past(pc) || pc == $past(pc) + 32'd4 || is_branch_target(pc))
        else begin
            $error("pc moved to %h at time %0t, which is no hold, step or target",
                   $sampled(pc), $time);
            error_count++;
        end

    // A load-use stall holds pc for one cycle only
    pc_hold_check: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> !(pc == $past(pc) && pc == $past(pc, 2)))
        else begin
            $error("pc held %h for more than one cycle at time %0t", $sampled(pc), $time);
            error_count++;
        end

    store_count_check: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> store_idx < STORE_COUNT)
        else begin
            $error("More stores than expected at time %0t", $time);
            error_count++;
        end

    store_addr_check: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> data_addr == EXP_ADDR[store_idx])
        else begin
            $error("Fail at time %0t: data_addr expected %h, got %h", $time,
                   EXP_ADDR[$sampled(store_idx)], $sampled(data_addr));
            error_count++;
        end

    store_data_check: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> wr_data == EXP_DATA[store_idx])
        else begin
            $error("Fail at time %0t: wr_data expected %h, got %h", $time,
                   EXP_DATA[$sampled(store_idx)], $sampled(wr_data));
            error_count++;
        end

    store_no_read_check: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> !mem_rd_en)
        else begin
            $error("Store raised mem_rd_en at time %0t", $time);
            error_count++;
        end

    poison_check: assert property (@(posedge clk) disable iff (reset)
        mem_wr_en |-> data_addr != POISON_ADDR)
        else begin
            $error("A flushed store reached the poison address at time %0t", $time);
            error_count++;
        end

    load_addr_check: assert property (@(posedge clk) disable iff (reset)
        mem_rd_en |-> data_addr == LOAD_ADDR)
        else begin
            $error("Fail at time %0t: data_addr expected %h, got %h", $time,
                   LOAD_ADDR, $sampled(data_addr));
            error_count++;
        end

    // Every store has left the pipeline by the time the halt loop is fetched
    completion_check: assert property (@(posedge clk) disable iff (reset)
        pc == HALT_PC && !halt_seen |-> store_idx == STORE_COUNT)
        else begin
            $error("Fail at time %0t: store count expected %0d, got %0d", $time,
                   STORE_COUNT, $sampled(store_idx));
            error_count++;
        end

endmodule

bind riscv_cpu riscv_cpu_properties #(
    .RESET_PC(RESET_PC)
) props0 (
    .clk(clk),
    .reset(reset),
    .pc(pc),
    .data_addr(data_addr),
    .wr_data(wr_data),
    .mem_wr_en(mem_wr_en),
    .mem_rd_en(mem_rd_en)
);

//--- sim/riscv_cpu_tb.sv
module riscv_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "riscv_cpu_program.svh"

    localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
    localparam int DATA_WORDS = 64;

    logic clk;
    logic reset;
    riscv_pkg::instr_t instr;
    riscv_pkg::word_t read_data;
    riscv_pkg::word_t pc;
    riscv_pkg::word_t data_addr;
    riscv_pkg::word_t wr_data;
    logic mem_wr_en;
    logic mem_rd_en;
    riscv_pkg::word_t data_mem [DATA_WORDS];
    int cycle_count = 0;

    riscv_cpu #(
        .RESET_PC(32'h0000_0000)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .read_data(read_data),
        .pc(pc),
        .data_addr(data_addr),
        .wr_data(wr_data),
        .mem_wr_en(mem_wr_en),
        .mem_rd_en(mem_rd_en)
    );

    always #10 clk = ~clk;

    // Instruction ROM returns NOP past the end of the program
    function automatic riscv_pkg::instr_t rom_word(riscv_pkg::word_t addr);
        if (addr[31:2] < PROG_LEN) begin
            return PROGRAM[addr[31:2]];
        end
        return riscv_pkg::NOP_INSTR;
    endfunction

    assign instr = rom_word(pc);

    // Data memory filled during reset with a pattern of the byte address
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                data_mem[i] <= 32'hd00d_0000 ^ (i * 4);
            end
        end else if (mem_wr_en) begin
            data_mem[data_addr[7:2]] <= wr_data;
        end
    end

    // Read data only appears while a load is on the port
    assign read_data = mem_rd_en ? data_mem[data_addr[7:2]] : '0;

    task automatic wait_for_halt();
        while (pc !== HALT_PC) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        wait_for_halt();
        // Let the halt loop spin a while
        repeat (10) @(negedge clk);
        if (dut0.props0.error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "One or more assertions on the DUT failed");
        end
    end

    // Stop at the first failed assertion
    always @(negedge clk) begin
        if (dut0.props0.error_count != 0) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "An assertion on the DUT failed");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout, pc did not reach the halt loop within %0d cycles",
                   TIMEOUT_CYCLES);
        end
    end

endmodule

//--- riscv_cpu.f
+incdir+sim
hw/riscv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/riscv_cpu.sv
sim/riscv_cpu_properties.sv
sim/riscv_cpu_tb.sv
